//--- design/wiscPkg.sv
/*
 * Shared types for the WISC-SP20 front end: instruction formats, opcodes,
 * the operation kinds and the records passed between queue, decode and execute
 */
package wiscPkg;

    // Supported opcodes, instr[15:11]
    localparam logic [4:0] opNop    = 5'b00001;
    localparam logic [4:0] opJ      = 5'b00100;
    localparam logic [4:0] opJr     = 5'b00101;
    localparam logic [4:0] opJal    = 5'b00110;
    localparam logic [4:0] opJalr   = 5'b00111;
    localparam logic [4:0] opAddi   = 5'b01000;
    localparam logic [4:0] opSubi   = 5'b01001;
    localparam logic [4:0] opXori   = 5'b01010;
    localparam logic [4:0] opAndni  = 5'b01011;
    localparam logic [4:0] opSlbi   = 5'b10010;
    localparam logic [4:0] opLbi    = 5'b11000;
    localparam logic [4:0] opRArith = 5'b11011;

    // R-format function select in instr[1:0]
    localparam logic [1:0] extAdd  = 2'b00;
    localparam logic [1:0] extSub  = 2'b01;
    localparam logic [1:0] extXor  = 2'b10;
    localparam logic [1:0] extAndn = 2'b11;

    typedef enum logic [3:0] {
        kindAdd, kindSub, kindXor, kindAndn, kindPassImm,
        kindSlbi, kindJump, kindLink, kindNop, kindIllegal
    } opKind;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [10:0] disp;
    } jFmtView;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } i1FmtView;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [7:0] imm;
    } i2FmtView;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] ext;
    } rFmtView;

    // The opcode field sits in the same place in every view
    typedef union packed {
        jFmtView  jFmt;
        i1FmtView i1Fmt;
        i2FmtView i2Fmt;
        rFmtView  rFmt;
    } wiscInstr;

    typedef struct packed {
        logic [15:0] pc;
        wiscInstr    instr;
    } fetchRec;

    typedef struct packed {
        logic [15:0] pc;
        opKind       kind;
        logic [15:0] rsVal;
        logic [15:0] rtVal;   // Second ALU operand, Rt or the I-format 1 immediate
        logic [15:0] imm;
        logic        regBase; // Jump target is Rs + imm instead of PC+2 + imm
        logic        wrEn;
        logic [2:0]  wrReg;
    } decodedOp;

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] nextPc;
        logic        wrEn;
        logic [2:0]  wrReg;
        logic [15:0] wrData;
        logic        illegal;
    } retireRec;

    typedef struct packed {
        logic        en;
        logic [2:0]  sel;
        logic [15:0] data;
    } regWrite;

endpackage

//--- design/instrQueue.sv
/*
 * Credit-controlled FIFO for fetched instructions. Entries land in a circular
 * buffer and move into a head register one cycle later; each pop of the head
 * hands one credit back to the source on the following cycle
 */
`timescale 1ns/1ps

module instrQueue #(
    parameter int QueueDepth = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             push,
    input  wiscPkg::fetchRec pushRec,
    input  logic             pop,
    output wiscPkg::fetchRec headRec,
    output logic             headValid,
    output logic             creditReturn
);

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    wiscPkg::fetchRec mem [QueueDepth];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  count;     // Entries in the buffer, not counting the head register
    logic [CntW:0]    occupancy;
    logic             loadHead;

    function automatic logic [PtrW-1:0] bumpPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Refill the head whenever it is empty or leaving this cycle
    assign loadHead  = (!headValid || pop) && (count != '0);
    assign occupancy = (CntW+1)'(count) + (CntW+1)'(headValid);

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= pushRec;
        if (loadHead) headRec <= mem[rdPtr];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            headValid    <= 1'b0;
            creditReturn <= 1'b0;
        end else begin
            if (push) wrPtr <= bumpPtr(wrPtr);
            if (loadHead) rdPtr <= bumpPtr(rdPtr);
            count <= count + CntW'(push) - CntW'(loadHead);
            if (loadHead) headValid <= 1'b1;
            else if (pop) headValid <= 1'b0;
            creditReturn <= pop; // One credit per entry leaving the queue
        end
    end

    // The source may only push with a credit in hand, so a full queue never sees a push
    assertNoOverflow: assert property (@(posedge clk) disable iff (!rstN)
        push |-> occupancy < (CntW+1)'(QueueDepth));

endmodule

//--- design/regFile.sv
/*
 * Eight 16-bit architectural registers with two combinational read ports and
 * one write port. A write is forwarded to a matching read in the same cycle
 */
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  logic [2:0]       rdSelA,
    input  logic [2:0]       rdSelB,
    output logic [15:0]      rdDataA,
    output logic [15:0]      rdDataB,
    input  wiscPkg::regWrite wr
);

    logic [15:0] regs [8];
    logic        hitA;
    logic        hitB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.sel] <= wr.data;
        end
    end

    // Bypass lets a dependent instruction in decode see the result retiring now
    assign hitA = wr.en && (wr.sel == rdSelA);
    assign hitB = wr.en && (wr.sel == rdSelB);

    assign rdDataA = hitA ? wr.data : regs[rdSelA];
    assign rdDataB = hitB ? wr.data : regs[rdSelB];

    // An unknown write would spread through the bypass into decode
    assertKnownWrite: assert property (@(posedge clk) disable iff (!rstN)
        wr.en |-> !$isunknown({wr.sel, wr.data}));

endmodule

//--- design/decodeStage.sv
/*
 * Decode stage. Splits the queue head by format, reads Rs and Rt, picks the
 * write register and forms the extended immediate, then registers the result
 * for execute whenever the op register is free or draining this cycle
 */
`timescale 1ns/1ps

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  wiscPkg::fetchRec  headRec,
    input  logic              headValid,
    output logic              pop,
    input  logic              opTaken,
    output wiscPkg::decodedOp op,
    output logic              opValid,
    output logic [2:0]        rdSelA,
    output logic [2:0]        rdSelB,
    input  logic [15:0]       rdDataA,
    input  logic [15:0]       rdDataB
);

    wiscPkg::wiscInstr instr;
    wiscPkg::decodedOp nxtOp;
    logic [4:0]        opcode;
    logic [15:0]       sext5;
    logic [15:0]       zext5;
    logic [15:0]       sext8;
    logic [15:0]       zext8;
    logic [15:0]       sext11;

    assign instr  = headRec.instr;
    assign opcode = instr.rFmt.opcode;
    assign rdSelA = instr.rFmt.rs;
    assign rdSelB = instr.rFmt.rt;

    assign sext5  = {{11{instr.i1Fmt.imm[4]}}, instr.i1Fmt.imm};
    assign zext5  = {11'b0, instr.i1Fmt.imm};
    assign sext8  = {{8{instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};
    assign zext8  = {8'b0, instr.i2Fmt.imm};
    assign sext11 = {{5{instr.jFmt.disp[10]}}, instr.jFmt.disp};

    always_comb begin
        nxtOp.pc      = headRec.pc;
        nxtOp.kind    = wiscPkg::kindIllegal; // Anything not listed below
        nxtOp.rsVal   = rdDataA;
        nxtOp.rtVal   = rdDataB;
        nxtOp.imm     = '0;
        nxtOp.regBase = 1'b0;
        nxtOp.wrEn    = 1'b0;
        nxtOp.wrReg   = '0;
        case (opcode)
            wiscPkg::opAddi, wiscPkg::opSubi: begin
                nxtOp.kind  = (opcode == wiscPkg::opAddi) ? wiscPkg::kindAdd : wiscPkg::kindSub;
                nxtOp.imm   = sext5;
                nxtOp.rtVal = sext5; // Immediate takes the place of Rt
                nxtOp.wrEn  = 1'b1;
                nxtOp.wrReg = instr.i1Fmt.rd;
            end
            wiscPkg::opXori, wiscPkg::opAndni: begin
                nxtOp.kind  = (opcode == wiscPkg::opXori) ? wiscPkg::kindXor : wiscPkg::kindAndn;
                nxtOp.imm   = zext5;
                nxtOp.rtVal = zext5;
                nxtOp.wrEn  = 1'b1;
                nxtOp.wrReg = instr.i1Fmt.rd;
            end
            wiscPkg::opLbi, wiscPkg::opSlbi: begin
                nxtOp.kind  = (opcode == wiscPkg::opLbi) ? wiscPkg::kindPassImm : wiscPkg::kindSlbi;
                nxtOp.imm   = (opcode == wiscPkg::opLbi) ? sext8 : zext8;
                nxtOp.wrEn  = 1'b1;
                nxtOp.wrReg = instr.i2Fmt.rs; // I-format 2 writes back to Rs
            end
            wiscPkg::opJ, wiscPkg::opJr: begin
                nxtOp.kind    = wiscPkg::kindJump;
                nxtOp.regBase = (opcode == wiscPkg::opJr);
                nxtOp.imm     = (opcode == wiscPkg::opJr) ? sext8 : sext11;
            end
            wiscPkg::opJal, wiscPkg::opJalr: begin
                nxtOp.kind    = wiscPkg::kindLink;
                nxtOp.regBase = (opcode == wiscPkg::opJalr);
                nxtOp.imm     = (opcode == wiscPkg::opJalr) ? sext8 : sext11;
                nxtOp.wrEn    = 1'b1;
                nxtOp.wrReg   = 3'd7; // Link register
            end
            wiscPkg::opRArith: begin
                nxtOp.wrEn  = 1'b1;
                nxtOp.wrReg = instr.rFmt.rd;
                case (instr.rFmt.ext)
                    wiscPkg::extAdd: nxtOp.kind = wiscPkg::kindAdd;
                    wiscPkg::extSub: nxtOp.kind = wiscPkg::kindSub;
                    wiscPkg::extXor: nxtOp.kind = wiscPkg::kindXor;
                    default:         nxtOp.kind = wiscPkg::kindAndn;
                endcase
            end
            wiscPkg::opNop: nxtOp.kind = wiscPkg::kindNop;
            default: ;
        endcase
    end

    // Take the head when execute is empty or retiring in this same cycle
    assign pop = headValid && (!opValid || opTaken);

    always_ff @(posedge clk) begin
        if (pop) op <= nxtOp;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) opValid <= 1'b0;
        else if (pop) opValid <= 1'b1;
        else if (opTaken) opValid <= 1'b0;
    end

endmodule

//--- design/executeStage.sv
/*
 * Execute stage. Computes the ALU, link and jump-target results for the held
 * op, writes the register file in the cycle it retires and sends a registered
 * retire record to the sink, one per credit held
 */
`timescale 1ns/1ps

module executeStage #(
    parameter int RetireCredits = 2
) (
    input  logic              clk,
    input  logic              rstN,
    input  wiscPkg::decodedOp op,
    input  logic              opValid,
    output logic              opTaken,
    output wiscPkg::regWrite  wr,
    output logic              retireValid,
    output wiscPkg::retireRec retire,
    input  logic              retireCreditReturn
);

    localparam int CreditW = $clog2(RetireCredits + 1);

    logic [CreditW-1:0] credits;
    logic [15:0]        pcPlus2;
    logic [15:0]        result;
    logic [15:0]        nxtPc;
    logic               isJump;

    assign pcPlus2 = op.pc + 16'd2;
    assign isJump  = (op.kind == wiscPkg::kindJump) || (op.kind == wiscPkg::kindLink);
    assign opTaken = opValid && (credits != '0); // Retire only with a credit in hand

    always_comb begin
        case (op.kind)
            wiscPkg::kindAdd:     result = op.rsVal + op.rtVal;
            wiscPkg::kindSub:     result = op.rtVal - op.rsVal; // ISA order is second minus Rs
            wiscPkg::kindXor:     result = op.rsVal ^ op.rtVal;
            wiscPkg::kindAndn:    result = op.rsVal & ~op.rtVal;
            wiscPkg::kindPassImm: result = op.imm;
            wiscPkg::kindSlbi:    result = {op.rsVal[7:0], 8'h00} | op.imm;
            wiscPkg::kindLink:    result = pcPlus2;
            default:              result = 16'h0000;
        endcase
    end

    // Register-based jumps add to Rs, the others to the next sequential PC
    always_comb begin
        if (!isJump) nxtPc = pcPlus2;
        else if (op.regBase) nxtPc = op.rsVal + op.imm;
        else nxtPc = pcPlus2 + op.imm;
    end

    always_comb begin
        wr.en   = opTaken && op.wrEn;
        wr.sel  = op.wrReg;
        wr.data = result;
    end

    always_ff @(posedge clk) begin
        if (opTaken) begin
            retire.pc      <= op.pc;
            retire.nextPc  <= nxtPc;
            retire.wrEn    <= op.wrEn;
            retire.wrReg   <= op.wrReg;
            retire.wrData  <= result;
            retire.illegal <= (op.kind == wiscPkg::kindIllegal);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits     <= CreditW'(RetireCredits);
            retireValid <= 1'b0;
        end else begin
            credits     <= credits + CreditW'(retireCreditReturn) - CreditW'(opTaken);
            retireValid <= opTaken;
        end
    end

    // A sink returning more credits than it was given would push this past the start value
    assertCreditBound: assert property (@(posedge clk) disable iff (!rstN)
        credits <= CreditW'(RetireCredits));

endmodule

//--- design/wiscCore.sv
/*
 * Top level of the WISC-SP20 front end. Fetched instructions enter the queue
 * under source credits, pass through decode and execute and leave as retire
 * records under sink credits
 */
`timescale 1ns/1ps

module wiscCore #(
    parameter int QueueDepth    = 4,
    parameter int RetireCredits = 2
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  wiscPkg::fetchRec  instrRec,
    output logic              instrCreditReturn,
    output logic              retireValid,
    output wiscPkg::retireRec retire,
    input  logic              retireCreditReturn
);

    wiscPkg::fetchRec  headRec;
    logic              headValid;
    logic              pop;
    wiscPkg::decodedOp op;
    logic              opValid;
    logic              opTaken;
    logic [2:0]        rdSelA;
    logic [2:0]        rdSelB;
    logic [15:0]       rdDataA;
    logic [15:0]       rdDataB;
    wiscPkg::regWrite  wr;

    instrQueue #(.QueueDepth(QueueDepth)) instrQueue_i (
        .clk(clk), .rstN(rstN),
        .push(instrValid), .pushRec(instrRec),
        .pop(pop), .headRec(headRec), .headValid(headValid),
        .creditReturn(instrCreditReturn)
    );

    decodeStage decodeStage_i (
        .clk(clk), .rstN(rstN),
        .headRec(headRec), .headValid(headValid), .pop(pop),
        .opTaken(opTaken), .op(op), .opValid(opValid),
        .rdSelA(rdSelA), .rdSelB(rdSelB), .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    regFile regFile_i (
        .clk(clk), .rstN(rstN),
        .rdSelA(rdSelA), .rdSelB(rdSelB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wr(wr)
    );

    executeStage #(.RetireCredits(RetireCredits)) executeStage_i (
        .clk(clk), .rstN(rstN),
        .op(op), .opValid(opValid), .opTaken(opTaken), .wr(wr),
        .retireValid(retireValid), .retire(retire),
        .retireCreditReturn(retireCreditReturn)
    );

endmodule

//--- sim/wiscRefModel.svh
/*
 * Reference model of the supported WISC-SP20 instructions for the core testbench.
 * Included inside the testbench module; modelStep applies one fetched word to
 * the model registers and returns the retire record the core should produce
 */
`ifndef WISC_REF_MODEL_SVH
`define WISC_REF_MODEL_SVH

logic [15:0] modelRegs [8]; // Architectural registers as the ISA sees them

function automatic wiscPkg::retireRec modelStep(input wiscPkg::fetchRec f);
    wiscPkg::retireRec r;
    logic [15:0] w;
    logic [15:0] rs;
    logic [15:0] rt;
    logic [15:0] pc2;
    logic [15:0] s5;
    logic [15:0] z5;
    logic [15:0] s8;
    logic [15:0] s11;
    w   = f.instr;
    pc2 = f.pc + 16'd2;
    rs  = modelRegs[w[10:8]];
    rt  = modelRegs[w[7:5]];
    s5  = {{11{w[4]}}, w[4:0]};
    z5  = {11'b0, w[4:0]};
    s8  = {{8{w[7]}}, w[7:0]};
    s11 = {{5{w[10]}}, w[10:0]};
    r        = '0;
    r.pc     = f.pc;
    r.nextPc = pc2;
    r.wrEn   = 1'b1;
    r.wrReg  = w[7:5];      // I-format 1 destination unless changed below
    case (w[15:11])
        wiscPkg::opAddi:  r.wrData = rs + s5;
        wiscPkg::opSubi:  r.wrData = s5 - rs; // Immediate minus Rs
        wiscPkg::opXori:  r.wrData = rs ^ z5;
        wiscPkg::opAndni: r.wrData = rs & ~z5;
        wiscPkg::opLbi: begin
            r.wrReg  = w[10:8];
            r.wrData = s8;
        end
        wiscPkg::opSlbi: begin
            r.wrReg  = w[10:8];
            r.wrData = {rs[7:0], w[7:0]};
        end
        wiscPkg::opRArith: begin
            r.wrReg = w[4:2];
            case (w[1:0])
                wiscPkg::extAdd: r.wrData = rs + rt;
                wiscPkg::extSub: r.wrData = rt - rs;
                wiscPkg::extXor: r.wrData = rs ^ rt;
                default:         r.wrData = rs & ~rt;
            endcase
        end
        wiscPkg::opJ: begin
            r.wrEn   = 1'b0;
            r.nextPc = pc2 + s11;
        end
        wiscPkg::opJr: begin
            r.wrEn   = 1'b0;
            r.nextPc = rs + s8;
        end
        wiscPkg::opJal: begin
            r.wrReg  = 3'd7;
            r.wrData = pc2;
            r.nextPc = pc2 + s11;
        end
        wiscPkg::opJalr: begin
            r.wrReg  = 3'd7;
            r.wrData = pc2;
            r.nextPc = rs + s8; // Old Rs, even when Rs is R7
        end
        wiscPkg::opNop: r.wrEn = 1'b0;
        default: begin
            r.wrEn    = 1'b0;
            r.illegal = 1'b1;
        end
    endcase
    if (r.wrEn) modelRegs[r.wrReg] = r.wrData;
    return r;
endfunction

`endif

//--- sim/wiscCoreTb.sv
/*
 * Testbench for wiscCore. A credit-respecting random source pushes supported and
 * illegal instructions, a sink hands retire credits back with random stalls, and
 * every retire record is compared in order against the reference model
 */
`timescale 1ns/1ps

module wiscCoreTb;

    localparam int QueueDepth    = 4;
    localparam int RetireCredits = 2;
    localparam int ResetCycles   = 16;
    localparam int NumInstr      = 600;
    localparam int TimeoutCycles = NumInstr * 8 + 100;

    localparam logic [4:0] LegalOps [12] = '{
        wiscPkg::opNop, wiscPkg::opJ, wiscPkg::opJr, wiscPkg::opJal, wiscPkg::opJalr,
        wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni,
        wiscPkg::opSlbi, wiscPkg::opLbi, wiscPkg::opRArith
    };

    logic              clk = 1'b0;
    logic              rstN;
    logic              instrValid;
    wiscPkg::fetchRec  instrRec;
    logic              instrCreditReturn;
    logic              retireValid;
    wiscPkg::retireRec retire;
    logic              retireCreditReturn;

    wiscPkg::retireRec expQ [$];  // Expected retires in push order
    int                srcCredits;
    int                sinkHeld;  // Retires received and not yet credited back
    int                stallLeft;
    int                pushed;
    int                retired;
    int                negCount;
    int                cycleCount;
    logic [2:0]        lastDst;
    int unsigned       seedInit;

    `include "wiscRefModel.svh"

    wiscCore #(.QueueDepth(QueueDepth), .RetireCredits(RetireCredits)) wiscCore_i (
        .clk(clk), .rstN(rstN),
        .instrValid(instrValid), .instrRec(instrRec),
        .instrCreditReturn(instrCreditReturn),
        .retireValid(retireValid), .retire(retire),
        .retireCreditReturn(retireCreditReturn)
    );

    always #5 clk = ~clk;

    task automatic abortRun();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, want);
            abortRun();
        end
    endtask

    function automatic logic isLegal(input logic [4:0] opc);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 12; i++) begin
            if (LegalOps[i] == opc) found = 1'b1;
        end
        return found;
    endfunction

    // About 5% illegal opcodes; half the words read the last written register
    function automatic wiscPkg::fetchRec randomInstr();
        wiscPkg::fetchRec f;
        logic [15:0]      word;
        logic [4:0]       opc;
        int               pick;
        word = 16'($urandom);
        if ($urandom_range(99) < 5) begin
            do begin
                opc = 5'($urandom_range(31));
            end while (isLegal(opc));
        end else begin
            pick = $urandom_range(11);
            opc  = LegalOps[pick];
        end
        word[15:11] = opc;
        if ($urandom_range(1) == 1) word[10:8] = lastDst;
        f.pc    = 16'($urandom) & 16'hFFFE;
        f.instr = word;
        return f;
    endfunction

    task automatic checkRetire(input wiscPkg::retireRec want);
        checkEq("retire.pc", retire.pc, want.pc);
        checkEq("retire.nextPc", retire.nextPc, want.nextPc);
        checkEq("retire.illegal", 16'(retire.illegal), 16'(want.illegal));
        checkEq("retire.wrEn", 16'(retire.wrEn), 16'(want.wrEn));
        if (want.wrEn) begin
            checkEq("retire.wrReg", 16'(retire.wrReg), 16'(want.wrReg));
            checkEq("retire.wrData", retire.wrData, want.wrData);
        end
    endtask

    // Sink side; long stalls fill the pipeline and then the queue
    task automatic returnCredit();
        retireCreditReturn = 1'b0;
        if (stallLeft > 0) begin
            stallLeft--;
        end else if ($urandom_range(99) < 3) begin
            stallLeft = 10 + $urandom_range(40);
        end else if (sinkHeld > 0 && $urandom_range(1) == 1) begin
            retireCreditReturn = 1'b1;
            sinkHeld--;
        end
    endtask

    task automatic pushInstr();
        wiscPkg::fetchRec  rec;
        wiscPkg::retireRec want;
        instrValid = 1'b0;
        if (srcCredits > 0 && pushed < NumInstr && $urandom_range(9) < 8) begin
            rec  = randomInstr();
            want = modelStep(rec);
            if (want.wrEn) lastDst = want.wrReg;
            expQ.push_back(want);
            instrRec   = rec;
            instrValid = 1'b1;
            srcCredits--;
            pushed++;
        end
    endtask

    always @(negedge clk) begin
        wiscPkg::retireRec want;
        negCount++;
        if (negCount <= ResetCycles) begin
            checkEq("retireValid", 16'(retireValid), 16'h0000);
            checkEq("instrCreditReturn", 16'(instrCreditReturn), 16'h0000);
            if (negCount == ResetCycles) rstN = 1'b1;
        end else begin
            if (instrCreditReturn) srcCredits++;
            if (retireValid) sinkHeld++;
            if (srcCredits > QueueDepth) begin
                $display("error: core returned more instruction credits than it was given");
                abortRun();
            end else if (sinkHeld > RetireCredits) begin
                $display("error: core retired without holding a retire credit");
                abortRun();
            end else if (retireValid && expQ.size() == 0) begin
                $display("error: retire record arrived with no instruction outstanding");
                abortRun();
            end else begin
                if (retireValid) begin
                    want = expQ.pop_front();
                    checkRetire(want);
                    retired++;
                end
                returnCredit();
                pushInstr();
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("error: timeout after %0d cycles, %0d of %0d instructions retired",
                     cycleCount, retired, NumInstr);
            abortRun();
        end
    end

    initial begin
        seedInit           = $urandom(32'h3891);
        rstN               = 1'b0;
        instrValid         = 1'b0;
        instrRec           = '0;
        retireCreditReturn = 1'b0;
        srcCredits         = QueueDepth;
        sinkHeld           = 0;
        stallLeft          = 0;
        pushed             = 0;
        retired            = 0;
        negCount           = 0;
        cycleCount         = 0;
        lastDst            = 3'd0;
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        wait (retired == NumInstr);
        repeat (20) @(posedge clk); // A duplicated retire would show up here
        if (srcCredits != QueueDepth) begin
            $display("error: %0d instruction credits never came back from the core",
                     QueueDepth - srcCredits);
            abortRun();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+sim
design/wiscPkg.sv
design/instrQueue.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/wiscCore.sv
sim/wiscCoreTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module wiscCoreTb -f files.f -o wiscSim
./obj_dir/wiscSim > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
